// File: rv_isa_pkg.sv
// rv32i encoding constants: opcodes, funct3, funct7 and instruction field types
package rv_isa_pkg;

    typedef logic [31:0] inst_t;    // raw instruction word
    typedef logic [4:0]  reg_idx_t; // x0..x31
    typedef logic [6:0]  opc_t;
    typedef logic [2:0]  f3_t;

    // major opcodes, inst[6:0]
    localparam opc_t OPC_OP     = 7'b0110011;
    localparam opc_t OPC_OP_IMM = 7'b0010011;
    localparam opc_t OPC_LUI    = 7'b0110111;

    // funct3, inst[14:12]
    localparam f3_t F3_ADD  = 3'b000; // add, sub, addi
    localparam f3_t F3_SLL  = 3'b001;
    localparam f3_t F3_SLT  = 3'b010;
    localparam f3_t F3_SLTU = 3'b011;
    localparam f3_t F3_XOR  = 3'b100;
    localparam f3_t F3_SR   = 3'b101; // srl and sra share this
    localparam f3_t F3_OR   = 3'b110;
    localparam f3_t F3_AND  = 3'b111;

    // funct7 that flips add to sub and srl to sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

// File: exu_pkg.sv
// execute datapath types and one-hot alu operation bit indices
package exu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      shamt_t;  // low five bits of operand b

    localparam int N_ALU_OPS = 11;

    // one bit per operation, exactly one set for a legal instruction
    typedef logic [N_ALU_OPS-1:0] alu_ops_t;

    // bit positions in alu_ops_t
    localparam int OP_ADD      = 0;
    localparam int OP_SUB      = 1;
    localparam int OP_SLT      = 2;
    localparam int OP_SLTU     = 3;
    localparam int OP_OR       = 4;
    localparam int OP_AND      = 5;
    localparam int OP_XOR      = 6;
    localparam int OP_SLL      = 7;
    localparam int OP_SRL      = 8;
    localparam int OP_SRA      = 9;
    localparam int OP_EXPLICIT = 10; // result = operand b, used by lui

endpackage

// File: alu_decoder.sv
// alu_decoder: rv32i op, op-imm and lui decode into one-hot alu lines and operands
`timescale 1ns/1ps

module alu_decoder (
    input  rv_isa_pkg::inst_t    inst,
    input  logic                 inst_valid,
    input  exu_pkg::word_t       rs1_data,
    input  exu_pkg::word_t       rs2_data,
    output logic                 dec_valid,
    output exu_pkg::alu_ops_t    ops,
    output exu_pkg::word_t       opa,
    output exu_pkg::word_t       opb,
    output rv_isa_pkg::reg_idx_t rd
);
    import rv_isa_pkg::*;
    import exu_pkg::*;

    opc_t        opcode;
    f3_t         funct3;
    logic [6:0]  funct7;
    logic        f7_zero;
    logic        f7_alt;
    word_t       imm_i;
    word_t       imm_u;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign f7_zero = (funct7 == 7'b0);
    assign f7_alt  = (funct7 == F7_ALT);

    assign imm_i = {{20{inst[31]}}, inst[31:20]}; // sign extended
    assign imm_u = {inst[31:12], 12'b0};

    assign dec_valid = inst_valid;
    assign opa       = rs1_data;
    assign rd        = inst[11:7];

    always_comb begin
        ops = '0;
        opb = rs2_data;
        case (opcode)
            OPC_OP: begin
                // register form, funct7 must be zero or the alternate value
                case (funct3)
                    F3_ADD: begin
                        ops[OP_ADD] = f7_zero;
                        ops[OP_SUB] = f7_alt;
                    end
                    F3_SLL:  ops[OP_SLL]  = f7_zero;
                    F3_SLT:  ops[OP_SLT]  = f7_zero;
                    F3_SLTU: ops[OP_SLTU] = f7_zero;
                    F3_XOR:  ops[OP_XOR]  = f7_zero;
                    F3_SR: begin
                        ops[OP_SRL] = f7_zero;
                        ops[OP_SRA] = f7_alt;
                    end
                    F3_OR:   ops[OP_OR]   = f7_zero;
                    F3_AND:  ops[OP_AND]  = f7_zero;
                    default: ops = '0;
                endcase
            end
            OPC_OP_IMM: begin
                opb = imm_i; // shifter only looks at imm[4:0]
                case (funct3)
                    F3_ADD:  ops[OP_ADD]  = 1'b1;
                    F3_SLL:  ops[OP_SLL]  = f7_zero;
                    F3_SLT:  ops[OP_SLT]  = 1'b1;
                    F3_SLTU: ops[OP_SLTU] = 1'b1;
                    F3_XOR:  ops[OP_XOR]  = 1'b1;
                    F3_SR: begin
                        ops[OP_SRL] = f7_zero;
                        ops[OP_SRA] = f7_alt;
                    end
                    F3_OR:   ops[OP_OR]   = 1'b1;
                    F3_AND:  ops[OP_AND]  = 1'b1;
                    default: ops = '0;
                endcase
            end
            OPC_LUI: begin
                opb              = imm_u;
                ops[OP_EXPLICIT] = 1'b1;
            end
            default: ops = '0; // unsupported, flagged illegal in execute
        endcase
    end

    // the execute stage relies on at most one line being set
    a_ops_onehot0: assert property (@(ops) $onehot0(ops))
        else $error("alu_decoder: multi-hot ops %b", ops);

endmodule

// File: id_ex_reg.sv
// id_ex_reg: decode to execute pipeline register with valid bit and stall hold
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 dec_valid,
    input  exu_pkg::alu_ops_t    ops,
    input  exu_pkg::word_t       opa,
    input  exu_pkg::word_t       opb,
    input  rv_isa_pkg::reg_idx_t rd,
    output logic                 ex_valid,
    output exu_pkg::alu_ops_t    ex_ops,
    output exu_pkg::word_t       ex_opa,
    output exu_pkg::word_t       ex_opb,
    output rv_isa_pkg::reg_idx_t ex_rd
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            ex_valid <= dec_valid;
        end
    end

    // payload, only qualified by ex_valid
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_ops <= ops;
            ex_opa <= opa;
            ex_opb <= opb;
            ex_rd  <= rd;
        end
    end

    // a stalled cycle must leave the whole entry untouched
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable(ex_valid) && $stable(ex_ops) && $stable(ex_opa)
                  && $stable(ex_opb) && $stable(ex_rd)
    ) else $error("id_ex_reg: contents changed during stall");

endmodule

// File: exu_shifter.sv
// exu_shifter: five stage log barrel shifter for sll, srl and sra
`timescale 1ns/1ps

module exu_shifter (
    input  exu_pkg::word_t  din,
    input  exu_pkg::shamt_t shamt,
    input  logic            left,
    input  logic            arith,
    output exu_pkg::word_t  dout
);
    import exu_pkg::*;

    logic  fill;
    word_t din_rev;
    word_t stage [0:5];
    word_t out_rev;

    // left shift = right shift of the bit reversed word
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            din_rev[i] = din[XLEN-1-i];
        end
    end

    assign fill     = arith & ~left & din[XLEN-1]; // sign fill for sra only
    assign stage[0] = left ? din_rev : din;

    for (genvar s = 0; s < 5; s++) begin : g_stage
        assign stage[s+1] = shamt[s] ? {{(1 << s){fill}}, stage[s][XLEN-1:(1 << s)]}
                                     : stage[s];
    end

    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            out_rev[i] = stage[5][XLEN-1-i];
        end
    end

    assign dout = left ? out_rev : stage[5];

endmodule

// File: exu_alu.sv
// add/sub, compare, logic and shift select with write enable and illegal flag
`timescale 1ns/1ps

module exu_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  exu_pkg::alu_ops_t ex_ops,
    input  exu_pkg::word_t    ex_opa,
    input  exu_pkg::word_t    ex_opb,
    output exu_pkg::word_t    result,
    output logic              cmp_less,
    output logic              cmp_zero,
    output logic              rd_wen,
    output logic              illegal
);
    import exu_pkg::*;

    logic     sub_en;
    logic     is_unsigned;
    word_t    opb_inv;
    word_t    add_sum;
    logic     add_carry;
    logic     add_ovf;
    word_t    shift_out;
    alu_ops_t ops_m1;
    logic     ops_any;
    logic     ops_one;

    assign sub_en      = ex_ops[OP_SUB] | ex_ops[OP_SLT] | ex_ops[OP_SLTU];
    assign is_unsigned = ex_ops[OP_SLTU];

    // single adder doing a + ~b + 1 when subtracting
    assign opb_inv = {XLEN{sub_en}} ^ ex_opb;
    assign {add_carry, add_sum} = {1'b0, ex_opa} + {1'b0, opb_inv} + {{XLEN{1'b0}}, sub_en};

    assign add_ovf = (ex_opa[XLEN-1] == opb_inv[XLEN-1])
                   && (ex_opa[XLEN-1] != add_sum[XLEN-1]);

    assign cmp_zero = (add_sum == '0);
    assign cmp_less = is_unsigned ? ~add_carry               // borrow out
                                  : add_ovf ^ add_sum[XLEN-1];

    exu_shifter u_shifter (
        .din   (ex_opa),
        .shamt (ex_opb[4:0]),
        .left  (ex_ops[OP_SLL]),
        .arith (ex_ops[OP_SRA]),
        .dout  (shift_out)
    );

    // and-or mux relying on one-hot ops
    assign result = ({XLEN{ex_ops[OP_ADD] | ex_ops[OP_SUB]}}  & add_sum)
                  | ({XLEN{ex_ops[OP_SLT] | ex_ops[OP_SLTU]}} & {{(XLEN-1){1'b0}}, cmp_less})
                  | ({XLEN{ex_ops[OP_OR]}}                    & (ex_opa | ex_opb))
                  | ({XLEN{ex_ops[OP_AND]}}                   & (ex_opa & ex_opb))
                  | ({XLEN{ex_ops[OP_XOR]}}                   & (ex_opa ^ ex_opb))
                  | ({XLEN{ex_ops[OP_SLL] | ex_ops[OP_SRL] | ex_ops[OP_SRA]}} & shift_out)
                  | ({XLEN{ex_ops[OP_EXPLICIT]}}              & ex_opb);

    // x & (x-1) clears the lowest set bit
    assign ops_m1  = ex_ops - alu_ops_t'(1);
    assign ops_any = |ex_ops;
    assign ops_one = ops_any && !(|(ex_ops & ops_m1));

    assign rd_wen  = ex_valid & ops_one;
    assign illegal = ex_valid & ~ops_any;

    // a multi-hot entry would be neither written nor flagged illegal
    a_wen_illegal_excl: assert property (
        @(posedge clk) disable iff (!rst_n) ex_valid |-> (rd_wen ^ illegal)
    ) else $error("exu_alu: rd_wen and illegal not exclusive for a valid entry");

endmodule

// File: exu_top.sv
// exu_top: decoder, id/ex register and alu of the execute slice
`timescale 1ns/1ps

module exu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_valid,
    input  rv_isa_pkg::inst_t    inst,
    input  exu_pkg::word_t       rs1_data,
    input  exu_pkg::word_t       rs2_data,
    input  logic                 stall,
    output exu_pkg::word_t       result,
    output rv_isa_pkg::reg_idx_t rd,
    output logic                 rd_wen,
    output logic                 illegal,
    output logic                 cmp_less,
    output logic                 cmp_zero
);
    import rv_isa_pkg::*;
    import exu_pkg::*;

    // decode side
    logic     dec_valid;
    alu_ops_t dec_ops;
    word_t    dec_opa;
    word_t    dec_opb;
    reg_idx_t dec_rd;

    // execute side
    logic     ex_valid;
    alu_ops_t ex_ops;
    word_t    ex_opa;
    word_t    ex_opb;

    alu_decoder u_dec (
        .inst       (inst),
        .inst_valid (inst_valid),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dec_valid  (dec_valid),
        .ops        (dec_ops),
        .opa        (dec_opa),
        .opb        (dec_opb),
        .rd         (dec_rd)
    );

    id_ex_reg u_id_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .dec_valid (dec_valid),
        .ops       (dec_ops),
        .opa       (dec_opa),
        .opb       (dec_opb),
        .rd        (dec_rd),
        .ex_valid  (ex_valid),
        .ex_ops    (ex_ops),
        .ex_opa    (ex_opa),
        .ex_opb    (ex_opb),
        .ex_rd     (rd)        // destination goes straight out
    );

    exu_alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_valid (ex_valid),
        .ex_ops   (ex_ops),
        .ex_opa   (ex_opa),
        .ex_opb   (ex_opb),
        .result   (result),
        .cmp_less (cmp_less),
        .cmp_zero (cmp_zero),
        .rd_wen   (rd_wen),
        .illegal  (illegal)
    );

endmodule

// File: tb_exu_top.sv
// directed testbench for the execute slice with isa reference model and timeout
`timescale 1ns/1ps

module tb_exu_top;
    import rv_isa_pkg::*;
    import exu_pkg::*;

    localparam int N_RAND      = 200;
    localparam int N_CMP_RAND  = 40;
    localparam int N_LUI       = 20;
    localparam int CYCLE_LIMIT = 16 + 2 + N_RAND * 9 + (6 + N_CMP_RAND) * 4 + 32 * 6
                               + N_LUI + 16 + 200; // tests plus margin

    logic     clk;
    logic     rst_n;
    logic     inst_valid;
    inst_t    inst;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     stall;
    word_t    result;
    reg_idx_t rd;
    logic     rd_wen;
    logic     illegal;
    logic     cmp_less;
    logic     cmp_zero;

    word_t       rng_state;
    logic [32:0] last_exp;  // {legal, result} of the last issued instruction
    int          n_checks;
    int          n_errors;
    int          cycle_count;

    exu_top i_exu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .stall      (stall),
        .result     (result),
        .rd         (rd),
        .rd_wen     (rd_wen),
        .illegal    (illegal),
        .cmp_less   (cmp_less),
        .cmp_zero   (cmp_zero)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic word_t xorshift32();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic inst_t r_type(input logic [6:0] f7, input f3_t f3, input reg_idx_t rd_i);
        return {f7, 5'd2, 5'd1, f3, rd_i, OPC_OP};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input f3_t f3, input reg_idx_t rd_i);
        return {imm, 5'd1, f3, rd_i, OPC_OP_IMM};
    endfunction

    function automatic inst_t u_type(input logic [19:0] imm, input reg_idx_t rd_i);
        return {imm, rd_i, OPC_LUI};
    endfunction

    // rv32i semantics from the encoding giving {legal, result}
    function automatic logic [32:0] rv32i_model(input inst_t ins, input word_t a, input word_t b);
        opc_t       op;
        f3_t        f3;
        logic [6:0] f7;
        logic       reg_form;
        logic       ok;
        word_t      src2;
        word_t      y;
        shamt_t     sh;
        op       = ins[6:0];
        f3       = ins[14:12];
        f7       = ins[31:25];
        reg_form = (op == OPC_OP);
        src2     = reg_form ? b : {{20{ins[31]}}, ins[31:20]};
        sh       = src2[4:0];
        y        = '0;
        if (op == OPC_LUI) begin
            return {1'b1, ins[31:12], 12'h000};
        end
        if (op != OPC_OP && op != OPC_OP_IMM) begin
            return {1'b0, 32'h0};
        end
        // alternate funct7 only for sub and sra
        ok = (f7 == 7'h00) || (f7 == F7_ALT && ((f3 == F3_ADD && reg_form) || f3 == F3_SR));
        // imm bits are free for non-shift op-imm
        if (!reg_form && f3 != F3_SLL && f3 != F3_SR) begin
            ok = 1'b1;
        end
        case (f3)
            F3_ADD:  y = (reg_form && f7 == F7_ALT) ? a - src2 : a + src2;
            F3_SLL:  y = a << sh;
            F3_SLT:  y = ($signed(a) < $signed(src2)) ? 32'd1 : 32'd0;
            F3_SLTU: y = (a < src2) ? 32'd1 : 32'd0;
            F3_XOR:  y = a ^ src2;
            F3_SR: begin
                if (f7 == F7_ALT) begin
                    y = $signed(a) >>> sh;
                end else begin
                    y = a >> sh;
                end
            end
            F3_OR:   y = a | src2;
            default: y = a & src2;
        endcase
        return {ok, y};
    endfunction

    task automatic mismatch(input string sig, input word_t got, input word_t exp);
        n_errors++;
        $display("[ERROR] %0t ns %s: got %h, expected %h", $time, sig, got, exp);
    endtask

    task automatic expect_outputs(input word_t exp_res, input logic legal, input reg_idx_t exp_rd);
        n_checks++;
        assert (rd_wen === legal) else mismatch("rd_wen", rd_wen, legal);
        assert (illegal === !legal) else mismatch("illegal", illegal, !legal);
        if (legal) begin
            assert (result === exp_res) else mismatch("result", result, exp_res);
            assert (rd === exp_rd) else mismatch("rd", rd, exp_rd);
        end
    endtask

    // drive at edge + 1 ns and check right after the capturing edge
    task automatic exec_and_check(input inst_t ins, input word_t a, input word_t b);
        last_exp   = rv32i_model(ins, a, b);
        inst       = ins;
        rs1_data   = a;
        rs2_data   = b;
        inst_valid = 1'b1;
        @(posedge clk);
        #1;
        expect_outputs(last_exp[31:0], last_exp[32], ins[11:7]);
    endtask

    task automatic arith_logic_random();
        word_t    a;
        word_t    b;
        reg_idx_t r;
        for (int i = 0; i < N_RAND; i++) begin
            a = xorshift32();
            b = (i % 8 == 0) ? a : xorshift32(); // some equal pairs for cmp_zero
            r = 5'(xorshift32());
            exec_and_check(r_type(7'h00, F3_ADD, r), a, b);
            exec_and_check(r_type(F7_ALT, F3_ADD, r), a, b);
            assert (cmp_zero === (a == b)) else mismatch("cmp_zero", cmp_zero, a == b);
            exec_and_check(r_type(7'h00, F3_AND, r), a, b);
            exec_and_check(r_type(7'h00, F3_OR, r), a, b);
            exec_and_check(r_type(7'h00, F3_XOR, r), a, b);
            exec_and_check(i_type(b[11:0], F3_ADD, r), a, b);
            exec_and_check(i_type(b[11:0], F3_AND, r), a, b);
            exec_and_check(i_type(b[11:0], F3_OR, r), a, b);
            exec_and_check(i_type(b[11:0], F3_XOR, r), a, b);
        end
    endtask

    task automatic compare_ops();
        word_t pa [0:5];
        word_t pb [0:5];
        word_t a;
        word_t b;
        pa = '{32'h8000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h0, 32'h5, 32'h7fff_ffff};
        pb = '{32'h0000_0001, 32'h8000_0000, 32'h0, 32'hffff_ffff, 32'h5, 32'h8000_0000};
        for (int i = 0; i < 6 + N_CMP_RAND; i++) begin
            if (i < 6) begin
                a = pa[i];
                b = pb[i];
            end else begin
                a = xorshift32();
                b = xorshift32();
            end
            exec_and_check(r_type(7'h00, F3_SLT, 5'd3), a, b);
            assert (cmp_less === last_exp[0]) else mismatch("cmp_less", cmp_less, last_exp[0]);
            exec_and_check(r_type(7'h00, F3_SLTU, 5'd4), a, b);
            assert (cmp_less === last_exp[0]) else mismatch("cmp_less", cmp_less, last_exp[0]);
            // imm is b[11:0], so 1, 0 and -1 come from the corner pairs
            exec_and_check(i_type(b[11:0], F3_SLT, 5'd5), a, b);
            exec_and_check(i_type(b[11:0], F3_SLTU, 5'd6), a, b);
        end
    endtask

    task automatic shift_sweep();
        word_t a;
        word_t neg;
        word_t b;
        for (int sh = 0; sh < 32; sh++) begin
            a   = xorshift32();
            neg = xorshift32() | 32'h8000_0000; // sign fill visible on sra
            b   = {27'(xorshift32() >> 5), 5'(sh)}; // upper bits must be ignored
            exec_and_check(r_type(7'h00, F3_SLL, 5'd7), a, b);
            exec_and_check(r_type(7'h00, F3_SR, 5'd8), a, b);
            exec_and_check(r_type(F7_ALT, F3_SR, 5'd9), neg, b);
            exec_and_check(i_type({7'h00, 5'(sh)}, F3_SLL, 5'd10), a, b);
            exec_and_check(i_type({7'h00, 5'(sh)}, F3_SR, 5'd11), a, b);
            exec_and_check(i_type({F7_ALT, 5'(sh)}, F3_SR, 5'd12), neg, b);
        end
    endtask

    task automatic lui_upper();
        word_t r;
        for (int i = 0; i < N_LUI; i++) begin
            r = xorshift32();
            exec_and_check(u_type(r[31:12], r[4:0]), xorshift32(), xorshift32());
        end
    endtask

    task automatic illegal_encodings();
        exec_and_check({25'(xorshift32() >> 7), 7'b0010111}, 32'h1, 32'h2); // auipc is not supported
        exec_and_check({25'(xorshift32() >> 7), 7'b1111111}, 32'h1, 32'h2);
        exec_and_check(i_type({7'b0000001, 5'd3}, F3_SLL, 5'd13), 32'h1, 32'h2);
        exec_and_check(i_type({7'b0100001, 5'd3}, F3_SR, 5'd14), 32'h1, 32'h2);
        exec_and_check(r_type(7'b0000001, F3_ADD, 5'd15), 32'h1, 32'h2); // mul
        exec_and_check(r_type(F7_ALT, F3_SLT, 5'd16), 32'h1, 32'h2);
        // an illegal word without inst_valid raises nothing
        inst_valid = 1'b0;
        @(posedge clk);
        #1;
        assert (rd_wen === 1'b0) else mismatch("rd_wen", rd_wen, 1'b0);
        assert (illegal === 1'b0) else mismatch("illegal", illegal, 1'b0);
    endtask

    task automatic stall_hold();
        inst_t held;
        inst_t next;
        logic [32:0] held_exp;
        logic [32:0] next_exp;
        held = r_type(7'h00, F3_ADD, 5'd17);
        next = r_type(7'h00, F3_XOR, 5'd18);
        exec_and_check(held, 32'h1234_0000, 32'h0000_5678);
        held_exp = last_exp;
        next_exp = rv32i_model(next, 32'hf0f0_f0f0, 32'h0ff0_0ff0);
        stall    = 1'b1;
        inst     = next;
        rs1_data = 32'hf0f0_f0f0;
        rs2_data = 32'h0ff0_0ff0;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #1;
            expect_outputs(held_exp[31:0], held_exp[32], held[11:7]);
        end
        stall = 1'b0;
        @(posedge clk);
        #1;
        expect_outputs(next_exp[31:0], next_exp[32], next[11:7]);
        inst_valid = 1'b0;
    endtask

    initial begin
        rng_state   = 32'd26921;
        n_checks    = 0;
        n_errors    = 0;
        cycle_count = 0;
        rst_n       = 1'b0;
        stall       = 1'b0;
        inst_valid  = 1'b1; // valid during reset must not leak through
        inst        = r_type(7'h00, F3_ADD, 5'd1);
        rs1_data    = '0;
        rs2_data    = '0;
        repeat (16) @(posedge clk);
        #1;
        // still in reset with a legal add presented
        assert (rd_wen === 1'b0) else mismatch("rd_wen", rd_wen, 1'b0);
        assert (illegal === 1'b0) else mismatch("illegal", illegal, 1'b0);
        rst_n      = 1'b1;
        inst_valid = 1'b0;
        @(posedge clk);
        #1;
        assert (rd_wen === 1'b0) else mismatch("rd_wen", rd_wen, 1'b0);
        assert (illegal === 1'b0) else mismatch("illegal", illegal, 1'b0);

        arith_logic_random();
        compare_ops();
        shift_sweep();
        lui_upper();
        illegal_encodings();
        stall_hold();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: exu_top.f
rv_isa_pkg.sv
exu_pkg.sv
alu_decoder.sv
id_ex_reg.sv
exu_shifter.sv
exu_alu.sv
exu_top.sv
tb_exu_top.sv

// File: Bender.yml
package:
  name: exu_top

sources:
  - rv_isa_pkg.sv
  - exu_pkg.sv
  - alu_decoder.sv
  - id_ex_reg.sv
  - exu_shifter.sv
  - exu_alu.sv
  - exu_top.sv
  - target: test
    files:
      - tb_exu_top.sv
